/* source/icache_pkg.sv */
`default_nettype none

package icache_pkg;

  //////////////////////////////////////////////////////////////////////
  // cache geometry
  //////////////////////////////////////////////////////////////////////

  // physical byte address and fetch word
  localparam int unsigned ADDR_WIDTH   = 16;
  localparam int unsigned WORD_WIDTH   = 32;
  // one line holds four fetch words
  localparam int unsigned LINE_WORDS   = 4;
  localparam int unsigned LINE_WIDTH   = LINE_WORDS * WORD_WIDTH;
  localparam int unsigned OFFSET_WIDTH = $clog2(LINE_WIDTH / 8);
  localparam int unsigned NUM_SETS     = 16;
  localparam int unsigned INDEX_WIDTH  = $clog2(NUM_SETS);
  // whatever is left above index and offset
  localparam int unsigned TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
  localparam int unsigned NUM_WAYS     = 2;
  localparam int unsigned WAY_WIDTH    = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;
  // random replacement source
  localparam int unsigned LFSR_WIDTH   = 8;

  //////////////////////////////////////////////////////////////////////
  // vector types
  //////////////////////////////////////////////////////////////////////

  typedef logic [ADDR_WIDTH-1:0]   addr_t;
  typedef logic [WORD_WIDTH-1:0]   word_t;
  typedef logic [LINE_WIDTH-1:0]   line_t;
  typedef logic [TAG_WIDTH-1:0]    tag_t;
  typedef logic [INDEX_WIDTH-1:0]  index_t;
  typedef logic [OFFSET_WIDTH-1:0] offset_t;
  typedef logic [WAY_WIDTH-1:0]    way_t;
  typedef logic [NUM_WAYS-1:0]     way_mask_t;

  // refill request towards memory
  typedef struct packed {
    addr_t addr;
    logic  nc;
    way_t  way;
  } mem_req_t;

  // controller command to the tag and data stores
  typedef struct packed {
    logic      rd;
    logic      wr;
    logic      clear;
    index_t    index;
    tag_t      tag;
    way_mask_t wr_way;
  } arr_req_t;

  // controller FSM
  typedef enum logic [1:0] {
    FLUSH,
    IDLE,
    READ,
    MISS
  } ctrl_state_e;

endpackage

`default_nettype wire

/* source/icache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl import icache_pkg::*; (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire logic     flush_i,
  input  wire logic     en_i,
  input  wire logic     fetch_req_i,
  input  wire addr_t    fetch_addr_i,
  output logic          fetch_ready_o,
  output logic          fetch_valid_o,
  output logic          miss_o,
  output logic          mem_req_o,
  output mem_req_t      mem_req_data_o,
  input  wire logic     mem_ack_i,
  input  wire logic     mem_rtrn_vld_i,
  input  wire logic     hit_i,
  input  wire way_t     repl_way_i,
  output logic          lfsr_step_o,
  output arr_req_t      arr_req_o,
  output logic          cmp_en_o,
  output offset_t       offset_o
);

  ctrl_state_e state_d, state_q;
  // latched request address and its cacheability
  addr_t       addr_q;
  logic        nc_q;
  logic        accept;
  // enable, pending flush and compare enable
  logic        cache_en_d, cache_en_q;
  logic        flush_d, flush_q;
  logic        cmp_en_d, cmp_en_q;
  // flush walks all sets once
  index_t      flush_cnt_q;
  logic        flush_done;
  // replacement way, frozen after the first compare
  way_t        repl_way_d, repl_way_q;
  way_mask_t   wr_way_oh;
  // array strobes
  logic        arr_rd, arr_wr, arr_clear;

  assign accept     = fetch_req_i & fetch_ready_o;
  assign flush_done = (flush_cnt_q == index_t'(NUM_SETS - 1));

  //////////////////////////////////////////////////////////////////////
  // main FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    // disabling takes effect at once, enabling goes through FLUSH
    cache_en_d    = cache_en_q & en_i;
    flush_d       = flush_q | flush_i;
    cmp_en_d      = 1'b0;
    arr_rd        = 1'b0;
    arr_wr        = 1'b0;
    arr_clear     = 1'b0;
    fetch_ready_o = 1'b0;
    fetch_valid_o = 1'b0;
    mem_req_o     = 1'b0;
    miss_o        = 1'b0;

    unique case (state_q)
      // clear one set per cycle
      FLUSH: begin
        arr_clear = 1'b1;
        if (flush_done) begin
          state_d    = IDLE;
          flush_d    = 1'b0;
          cache_en_d = en_i;
        end
      end
      IDLE: begin
        cmp_en_d = cache_en_q;
        // pending flush or a rising enable empties the cache first
        if (flush_d || (en_i && !cache_en_q)) begin
          state_d = FLUSH;
        end else begin
          fetch_ready_o = 1'b1;
          if (fetch_req_i) begin
            arr_rd  = 1'b1;
            state_d = READ;
          end
        end
      end
      // lookup result is on the array outputs
      READ: begin
        cmp_en_d = cache_en_q;
        if (hit_i && cmp_en_q) begin
          fetch_valid_o = 1'b1;
          state_d       = IDLE;
          // back to back lookup, unless a flush waits
          if (!flush_d) begin
            fetch_ready_o = 1'b1;
            if (fetch_req_i) begin
              arr_rd  = 1'b1;
              state_d = READ;
            end
          end
        end else begin
          // miss or nc access, hold the request until acknowledge
          cmp_en_d  = 1'b0;
          mem_req_o = 1'b1;
          if (mem_ack_i) begin
            miss_o  = ~nc_q;
            state_d = MISS;
          end
        end
      end
      // refill line arrives in a single cycle
      MISS: begin
        if (mem_rtrn_vld_i) begin
          fetch_valid_o = 1'b1;
          arr_wr        = ~nc_q;
          state_d       = IDLE;
        end
      end
      default: state_d = FLUSH;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // replacement way and array command
  //////////////////////////////////////////////////////////////////////

  // sample the selector only while the lookup data is fresh
  assign repl_way_d = cmp_en_q ? repl_way_i : repl_way_q;

  always_comb begin
    wr_way_oh             = '0;
    wr_way_oh[repl_way_q] = 1'b1;
  end

  assign lfsr_step_o = arr_wr;

  assign arr_req_o.rd     = arr_rd;
  assign arr_req_o.wr     = arr_wr;
  assign arr_req_o.clear  = arr_clear;
  // flush counter, refill index, or index of the incoming request
  assign arr_req_o.index  = arr_clear ? flush_cnt_q :
                            arr_wr    ? addr_q[OFFSET_WIDTH +: INDEX_WIDTH] :
                                        fetch_addr_i[OFFSET_WIDTH +: INDEX_WIDTH];
  assign arr_req_o.tag    = addr_q[ADDR_WIDTH-1 -: TAG_WIDTH];
  assign arr_req_o.wr_way = wr_way_oh;

  assign cmp_en_o = cmp_en_q;
  assign offset_o = addr_q[OFFSET_WIDTH-1:0];

  // nc requests are word aligned, cacheable ones line aligned
  assign mem_req_data_o.addr = nc_q ? {addr_q[ADDR_WIDTH-1:2], 2'b00} :
                               {addr_q[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
  assign mem_req_data_o.nc   = nc_q;
  assign mem_req_data_o.way  = repl_way_d;

  //////////////////////////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= FLUSH;
      cache_en_q  <= 1'b0;
      flush_q     <= 1'b0;
      cmp_en_q    <= 1'b0;
      flush_cnt_q <= '0;
      repl_way_q  <= '0;
      nc_q        <= 1'b0;
    end else begin
      state_q    <= state_d;
      cache_en_q <= cache_en_d;
      flush_q    <= flush_d;
      cmp_en_q   <= cmp_en_d;
      repl_way_q <= repl_way_d;
      if (flush_done) begin
        flush_cnt_q <= '0;
      end else if (arr_clear) begin
        flush_cnt_q <= flush_cnt_q + 1'b1;
      end
      // disabled cache turns every access nc
      if (accept) begin
        nc_q <= ~cache_en_q;
      end
    end
  end

  // request address, payload only
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= fetch_addr_i;
    end
  end

  state_legal: assert property (
    @(posedge clk_i) disable iff (!rst_ni) state_q inside {FLUSH, IDLE, READ, MISS})
    else $error("icache_ctrl: illegal state");

  // refill request must not move while memory stalls
  req_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (mem_req_o && !mem_ack_i) |=> (mem_req_o && $stable(mem_req_data_o)))
    else $error("icache_ctrl: memory request changed before acknowledge");

endmodule

`default_nettype wire

/* source/icache_arrays.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_arrays import icache_pkg::*; (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire arr_req_t                  arr_req_i,
  input  wire line_t                     wr_line_i,
  output tag_t      [NUM_WAYS-1:0]       tags_o,
  output way_mask_t                      valid_o,
  output line_t     [NUM_WAYS-1:0]       lines_o
);

  // one tag, valid and line store per way
  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_way
    tag_t                tag_mem  [NUM_SETS];
    line_t               line_mem [NUM_SETS];
    logic [NUM_SETS-1:0] vld_mem;
    logic                wr_en;

    // refill goes to the masked way only
    assign wr_en = arr_req_i.wr & arr_req_i.wr_way[w];

    // tag and line store, synchronous read
    always_ff @(posedge clk_i) begin
      if (wr_en) begin
        tag_mem[arr_req_i.index]  <= arr_req_i.tag;
        line_mem[arr_req_i.index] <= wr_line_i;
      end
      if (arr_req_i.rd) begin
        tags_o[w]  <= tag_mem[arr_req_i.index];
        lines_o[w] <= line_mem[arr_req_i.index];
      end
    end

    // valid bits, cleared set by set in FLUSH
    always_ff @(posedge clk_i) begin
      if (arr_req_i.clear) begin
        vld_mem[arr_req_i.index] <= 1'b0;
      end else if (wr_en) begin
        vld_mem[arr_req_i.index] <= 1'b1;
      end
    end

    // read valid flag, held until the next lookup
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        valid_o[w] <= 1'b0;
      end else if (arr_req_i.rd) begin
        valid_o[w] <= vld_mem[arr_req_i.index];
      end
    end
  end

  // controller never looks up while it fills or clears
  no_rd_wr: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    arr_req_i.rd |-> !(arr_req_i.wr || arr_req_i.clear))
    else $error("icache_arrays: read and write in the same cycle");

endmodule

`default_nettype wire

/* source/icache_hit_select.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_hit_select import icache_pkg::*; (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire tag_t  [NUM_WAYS-1:0]  tags_i,
  input  wire way_mask_t             valid_i,
  input  wire line_t [NUM_WAYS-1:0]  lines_i,
  input  wire logic                  cmp_en_i,
  input  wire tag_t                  tag_i,
  input  wire offset_t               offset_i,
  input  wire line_t                 rtrn_line_i,
  output logic                       hit_o,
  output word_t                      fetch_data_o
);

  way_mask_t                   hits;
  way_t                        hit_idx;
  // word number inside the line, byte bits dropped
  logic [OFFSET_WIDTH-3:0]     word_idx;

  // tag compare per way
  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_cmp
    assign hits[w] = valid_i[w] & (tags_i[w] == tag_i);
  end

  assign hit_o = |hits;

  // lowest hitting way wins
  always_comb begin
    hit_idx = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (hits[w]) begin
        hit_idx = way_t'(w);
      end
    end
  end

  assign word_idx = offset_i[OFFSET_WIDTH-1:2];

  // array line on lookup, returned line on refill or nc
  always_comb begin
    if (cmp_en_i) begin
      fetch_data_o = lines_i[hit_idx][word_idx*WORD_WIDTH +: WORD_WIDTH];
    end else begin
      fetch_data_o = rtrn_line_i[word_idx*WORD_WIDTH +: WORD_WIDTH];
    end
  end

  // a line is never resident in two ways at once
  hit_onehot: assert property (
    @(posedge clk_i) disable iff (!rst_ni) cmp_en_i |-> $onehot0(hits))
    else $error("icache_hit_select: more than one way hits");

endmodule

`default_nettype wire

/* source/icache_repl_sel.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_repl_sel import icache_pkg::*; (
  input  wire logic      clk_i,
  input  wire logic      rst_ni,
  input  wire way_mask_t valid_i,
  input  wire logic      step_i,
  output way_t           repl_way_o
);

  logic [LFSR_WIDTH-1:0] lfsr_q;
  logic                  feedback;
  logic                  all_valid;
  way_t                  inv_way;

  assign all_valid = &valid_i;

  // first invalid way, lowest number wins
  always_comb begin
    inv_way = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!valid_i[w]) begin
        inv_way = way_t'(w);
      end
    end
  end

  // taps 8,6,5,4, maximal length
  assign feedback = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

  // only step when a valid line is evicted
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= '1;
    end else if (step_i && all_valid) begin
      lfsr_q <= {lfsr_q[LFSR_WIDTH-2:0], feedback};
    end
  end

  assign repl_way_o = all_valid ? lfsr_q[WAY_WIDTH-1:0] : inv_way;

endmodule

`default_nettype wire

/* source/icache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_top import icache_pkg::*; (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire logic     flush_i,
  input  wire logic     en_i,
  input  wire logic     fetch_req_i,
  input  wire addr_t    fetch_addr_i,
  output logic          fetch_ready_o,
  output logic          fetch_valid_o,
  output word_t         fetch_data_o,
  output logic          miss_o,
  output logic          mem_req_o,
  output mem_req_t      mem_req_data_o,
  input  wire logic     mem_ack_i,
  input  wire logic     mem_rtrn_vld_i,
  input  wire line_t    mem_rtrn_data_i
);

  // controller to arrays and selectors
  arr_req_t                arr_req;
  logic                    cmp_en;
  offset_t                 offset;
  logic                    lfsr_step;
  // array read data
  tag_t  [NUM_WAYS-1:0]    tags;
  way_mask_t               valid;
  line_t [NUM_WAYS-1:0]    lines;
  // back to the controller
  logic                    hit;
  way_t                    repl_way;

  //////////////////////////////////////////////////////////////////////
  // request side
  //////////////////////////////////////////////////////////////////////

  icache_ctrl icache_ctrl_i (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .flush_i        ( flush_i        ),
    .en_i           ( en_i           ),
    .fetch_req_i    ( fetch_req_i    ),
    .fetch_addr_i   ( fetch_addr_i   ),
    .fetch_ready_o  ( fetch_ready_o  ),
    .fetch_valid_o  ( fetch_valid_o  ),
    .miss_o         ( miss_o         ),
    .mem_req_o      ( mem_req_o      ),
    .mem_req_data_o ( mem_req_data_o ),
    .mem_ack_i      ( mem_ack_i      ),
    .mem_rtrn_vld_i ( mem_rtrn_vld_i ),
    .hit_i          ( hit            ),
    .repl_way_i     ( repl_way       ),
    .lfsr_step_o    ( lfsr_step      ),
    .arr_req_o      ( arr_req        ),
    .cmp_en_o       ( cmp_en         ),
    .offset_o       ( offset         )
  );

  // storage, refill line written straight from memory
  icache_arrays icache_arrays_i (
    .clk_i     ( clk_i           ),
    .rst_ni    ( rst_ni          ),
    .arr_req_i ( arr_req         ),
    .wr_line_i ( mem_rtrn_data_i ),
    .tags_o    ( tags            ),
    .valid_o   ( valid           ),
    .lines_o   ( lines           )
  );

  //////////////////////////////////////////////////////////////////////
  // read data side
  //////////////////////////////////////////////////////////////////////

  icache_hit_select icache_hit_select_i (
    .clk_i        ( clk_i           ),
    .rst_ni       ( rst_ni          ),
    .tags_i       ( tags            ),
    .valid_i      ( valid           ),
    .lines_i      ( lines           ),
    .cmp_en_i     ( cmp_en          ),
    .tag_i        ( arr_req.tag     ),
    .offset_i     ( offset          ),
    .rtrn_line_i  ( mem_rtrn_data_i ),
    .hit_o        ( hit             ),
    .fetch_data_o ( fetch_data_o    )
  );

  icache_repl_sel icache_repl_sel_i (
    .clk_i      ( clk_i     ),
    .rst_ni     ( rst_ni    ),
    .valid_i    ( valid     ),
    .step_i     ( lfsr_step ),
    .repl_way_o ( repl_way  )
  );

endmodule

`default_nettype wire

/* verification/icache_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_checker import icache_pkg::*; (
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  input  wire logic       en_i,
  input  wire logic       fetch_req_i,
  input  wire addr_t      fetch_addr_i,
  input  wire logic       fetch_ready_i,
  input  wire logic       fetch_valid_i,
  input  wire word_t      fetch_data_i,
  input  wire logic       miss_i,
  input  wire logic       mem_req_i,
  input  wire mem_req_t   mem_req_data_i,
  input  wire logic       mem_ack_i,
  input  wire logic [7:0] test_id_i,
  input  wire logic       exp_req_i,
  input  wire logic [1:0] timeout_i,
  input  wire logic       done_i,
  output int              err_cnt_o
);

  // fetch in flight
  logic     busy;
  logic [7:0] id;
  addr_t    addr;
  logic     exp_req;
  logic     exp_nc;
  int       lat;
  int       req_cnt;
  int       miss_cnt;
  int       test_err;
  // request seen waiting in the previous cycle
  logic     prev_wait;
  mem_req_t prev_req;
  int       pass_cnt;
  int       fail_cnt;

  initial begin
    busy      = 1'b0;
    prev_wait = 1'b0;
    err_cnt_o = 0;
    pass_cnt  = 0;
    fail_cnt  = 0;
    test_err  = 0;
  end

  // memory word at A is A*0x00010001 xor 0x5a5a0000
  function automatic word_t expected_word(input addr_t a);
    logic [31:0] wa;
    wa = 32'(a) & 32'hffff_fffc;
    return (wa * 32'h0001_0001) ^ 32'h5a5a_0000;
  endfunction

  task automatic note_error(input string msg);
    $display("%s", msg);
    test_err++;
    err_cnt_o++;
  endtask

  //////////////////////////////////////////////////////////////////////
  // per request and per answer checks
  //////////////////////////////////////////////////////////////////////

  task automatic check_request();
    addr_t exp_addr;
    // nc requests are word aligned and refills line aligned
    exp_addr = exp_nc ? (addr & 16'hfffc) : (addr & 16'hfff0);
    req_cnt++;
    if (mem_req_data_i.addr != exp_addr)
      note_error($sformatf("MISMATCH mem_req_data_o.addr: got %h expected %h",
                           mem_req_data_i.addr, exp_addr));
    if (mem_req_data_i.nc != exp_nc)
      note_error($sformatf("MISMATCH mem_req_data_o.nc: got %h expected %h",
                           mem_req_data_i.nc, exp_nc));
  endtask

  task automatic close_test();
    word_t exp_data;
    int    exp_miss;
    exp_data = expected_word(addr);
    exp_miss = (exp_req && !exp_nc) ? 1 : 0;
    if (fetch_data_i !== exp_data)
      note_error($sformatf("MISMATCH fetch_data_o: got %h expected %h",
                           fetch_data_i, exp_data));
    if (exp_req && req_cnt == 0)
      note_error("expected a memory request but none was made");
    if (!exp_req && req_cnt != 0)
      note_error("memory request made although the line should hit");
    if (req_cnt > 1)
      note_error($sformatf("%0d memory requests for a single fetch", req_cnt));
    if (miss_cnt != exp_miss)
      note_error($sformatf("MISMATCH miss_o pulses: got %h expected %h", miss_cnt, exp_miss));
    // hit answers exactly one cycle after acceptance
    if (!exp_req && lat != 1)
      note_error($sformatf("hit answered after %0d cycles instead of 1", lat));
    // the hit cycle already takes the next fetch
    if (!exp_req && fetch_ready_i !== 1'b1)
      note_error($sformatf("MISMATCH fetch_ready_o: got %h expected %h",
                           fetch_ready_i, 1'b1));
    if (test_err == 0) begin
      pass_cnt++;
      $display("test %0d addr %h: passed", id, addr);
    end else begin
      fail_cnt++;
      $display("test %0d addr %h: failed with %0d errors", id, addr, test_err);
    end
    busy = 1'b0;
  endtask

  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (timeout_i == 2'd1) begin
        note_error($sformatf("test %0d: fetch_ready_o never came, timed out", test_id_i));
        fail_cnt++;
      end else if (timeout_i == 2'd2) begin
        note_error($sformatf("test %0d addr %h: no answer, timed out", id, addr));
        fail_cnt++;
        busy = 1'b0;
      end
      if (busy) begin
        lat++;
        if (prev_wait && !mem_req_i)
          note_error("memory request dropped before acknowledge");
        else if (prev_wait && mem_req_data_i != prev_req)
          note_error($sformatf("MISMATCH mem_req_data_o: got %h expected %h",
                               mem_req_data_i, prev_req));
        if (mem_req_i && mem_ack_i) check_request();
        if (miss_i) miss_cnt++;
        if (fetch_valid_i) close_test();
      end else begin
        if (mem_req_i && mem_ack_i) note_error("memory request with no fetch in flight");
        if (fetch_valid_i) note_error("answer with no fetch in flight");
      end
      // a new fetch may start back to back with an answer
      if (fetch_req_i && fetch_ready_i) begin
        busy     = 1'b1;
        id       = test_id_i;
        addr     = fetch_addr_i;
        exp_req  = exp_req_i;
        exp_nc   = ~en_i;
        lat      = 0;
        req_cnt  = 0;
        miss_cnt = 0;
        test_err = 0;
      end
      prev_wait = mem_req_i && !mem_ack_i;
      prev_req  = mem_req_data_i;
      if (done_i)
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt_o);
    end
  end

endmodule

`default_nettype wire

/* verification/icache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_tb import icache_pkg::*; ();

  localparam int unsigned RESET_CYCLES = 16;
  localparam int unsigned TIMEOUT      = 200;
  localparam int unsigned NUM_TESTS    = 23;

  typedef struct packed {
    addr_t addr;
    logic  en;
    logic  flush;
    logic  exp_req;
  } stim_t;

  // columns are address, en_i, flush before, memory request expected
  localparam stim_t STIM [NUM_TESTS] = '{
    '{16'h1234, 1'b1, 1'b0, 1'b1},  // cold miss
    '{16'h1238, 1'b1, 1'b0, 1'b0},
    '{16'h1230, 1'b1, 1'b0, 1'b0},
    '{16'h1236, 1'b1, 1'b0, 1'b0},  // low two bits ignored
    '{16'h2234, 1'b1, 1'b0, 1'b1},  // same set in the second way
    '{16'h1234, 1'b1, 1'b0, 1'b0},
    '{16'h223c, 1'b1, 1'b0, 1'b0},
    '{16'h3234, 1'b1, 1'b0, 1'b1},  // third tag evicts one way
    '{16'h3238, 1'b1, 1'b0, 1'b0},
    '{16'h3234, 1'b1, 1'b1, 1'b1},  // flush first
    '{16'h3230, 1'b1, 1'b0, 1'b0},
    '{16'h1234, 1'b0, 1'b0, 1'b1},  // disabled cache turns every access nc
    '{16'h1234, 1'b0, 1'b0, 1'b1},
    '{16'h4102, 1'b0, 1'b0, 1'b1},
    '{16'h3234, 1'b1, 1'b0, 1'b1},  // enabling again starts from an empty cache
    '{16'h3238, 1'b1, 1'b0, 1'b0},
    '{16'h5670, 1'b1, 1'b0, 1'b1},
    '{16'h6a0c, 1'b1, 1'b0, 1'b1},
    '{16'h7ffc, 1'b1, 1'b0, 1'b1},
    '{16'hfff0, 1'b1, 1'b0, 1'b1},
    '{16'h6a04, 1'b1, 1'b0, 1'b0},
    '{16'hfff4, 1'b1, 1'b0, 1'b0},
    '{16'h5674, 1'b1, 1'b0, 1'b0}
  };

  logic       clk_i;
  logic       rst_ni;
  logic       flush_i;
  logic       en_i;
  logic       fetch_req_i;
  addr_t      fetch_addr_i;
  logic       fetch_ready_o;
  logic       fetch_valid_o;
  word_t      fetch_data_o;
  logic       miss_o;
  logic       mem_req_o;
  mem_req_t   mem_req_data_o;
  logic       mem_ack_i;
  logic       mem_rtrn_vld_i;
  line_t      mem_rtrn_data_i;
  // towards the checker
  logic [7:0] test_id;
  logic       exp_req;
  logic [1:0] timeout_kind;
  logic       done;
  int         err_cnt;
  // memory model phase is 0 idle, 1 acknowledge delay or 2 return delay
  int unsigned mem_phase;
  int unsigned mem_cnt;
  addr_t       mem_addr;

  icache_top icache_top_i (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .flush_i         ( flush_i         ),
    .en_i            ( en_i            ),
    .fetch_req_i     ( fetch_req_i     ),
    .fetch_addr_i    ( fetch_addr_i    ),
    .fetch_ready_o   ( fetch_ready_o   ),
    .fetch_valid_o   ( fetch_valid_o   ),
    .fetch_data_o    ( fetch_data_o    ),
    .miss_o          ( miss_o          ),
    .mem_req_o       ( mem_req_o       ),
    .mem_req_data_o  ( mem_req_data_o  ),
    .mem_ack_i       ( mem_ack_i       ),
    .mem_rtrn_vld_i  ( mem_rtrn_vld_i  ),
    .mem_rtrn_data_i ( mem_rtrn_data_i )
  );

  icache_checker icache_checker_i (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .en_i           ( en_i           ),
    .fetch_req_i    ( fetch_req_i    ),
    .fetch_addr_i   ( fetch_addr_i   ),
    .fetch_ready_i  ( fetch_ready_o  ),
    .fetch_valid_i  ( fetch_valid_o  ),
    .fetch_data_i   ( fetch_data_o   ),
    .miss_i         ( miss_o         ),
    .mem_req_i      ( mem_req_o      ),
    .mem_req_data_i ( mem_req_data_o ),
    .mem_ack_i      ( mem_ack_i      ),
    .test_id_i      ( test_id        ),
    .exp_req_i      ( exp_req        ),
    .timeout_i      ( timeout_kind   ),
    .done_i         ( done           ),
    .err_cnt_o      ( err_cnt        )
  );

  always #4 clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // memory model
  //////////////////////////////////////////////////////////////////////

  function automatic word_t word_at(input addr_t a);
    return (32'(a) * 32'h0001_0001) ^ 32'h5a5a_0000;
  endfunction

  // whole line around an address with each word at its own offset
  function automatic line_t line_at(input addr_t a);
    line_t line;
    addr_t base;
    base = a & 16'hfff0;
    for (int i = 0; i < LINE_WORDS; i++) begin
      line[i*WORD_WIDTH +: WORD_WIDTH] = word_at(base + addr_t'(4 * i));
    end
    return line;
  endfunction

  // ack after 0 to 3 cycles and the line 1 to 4 cycles after the ack
  always @(negedge clk_i) begin
    mem_ack_i      = 1'b0;
    mem_rtrn_vld_i = 1'b0;
    if (!rst_ni) begin
      mem_phase = 0;
    end else begin
      if (mem_phase == 0 && mem_req_o) begin
        mem_addr  = mem_req_data_o.addr;
        mem_cnt   = $urandom % 4;
        mem_phase = 1;
      end
      if (mem_phase == 1) begin
        if (mem_cnt == 0) begin
          mem_ack_i = 1'b1;
          mem_cnt   = $urandom % 4;
          mem_phase = 2;
        end else begin
          mem_cnt--;
        end
      end else if (mem_phase == 2) begin
        if (mem_cnt == 0) begin
          mem_rtrn_vld_i  = 1'b1;
          mem_rtrn_data_i = line_at(mem_addr);
          mem_phase       = 0;
        end else begin
          mem_cnt--;
        end
      end
    end
  end

  // hold the timeout notice for one clock so the checker sees it
  task automatic report_timeout(input logic [1:0] kind);
    timeout_kind = kind;
    @(negedge clk_i);
    timeout_kind = 2'd0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    int unsigned t;
    logic        aborted;
    void'($urandom(32'hd406f3b0));
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    flush_i         = 1'b0;
    en_i            = 1'b1;
    fetch_req_i     = 1'b0;
    fetch_addr_i    = '0;
    mem_ack_i       = 1'b0;
    mem_rtrn_vld_i  = 1'b0;
    mem_rtrn_data_i = '0;
    mem_phase       = 0;
    mem_cnt         = 0;
    mem_addr        = '0;
    test_id         = '0;
    exp_req         = 1'b0;
    timeout_kind    = 2'd0;
    done            = 1'b0;
    aborted         = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_ni = 1'b1;

    for (int n = 0; n < NUM_TESTS && !aborted; n++) begin
      // mode and optional flush ahead of the request
      @(negedge clk_i);
      test_id = 8'(n);
      en_i    = STIM[n].en;
      flush_i = STIM[n].flush;
      @(negedge clk_i);
      flush_i = 1'b0;
      t = 0;
      while (!fetch_ready_o && t < TIMEOUT) begin
        @(negedge clk_i);
        t++;
      end
      if (!fetch_ready_o) begin
        report_timeout(2'd1);
        aborted = 1'b1;
      end else begin
        fetch_req_i  = 1'b1;
        fetch_addr_i = STIM[n].addr;
        exp_req      = STIM[n].exp_req;
        @(negedge clk_i);
        fetch_req_i = 1'b0;
        // the answer is sampled on the rising edge while the refill return is settled
        t = 0;
        @(posedge clk_i);
        while (!fetch_valid_o && t < TIMEOUT) begin
          @(posedge clk_i);
          t++;
        end
        if (!fetch_valid_o) begin
          @(negedge clk_i);
          report_timeout(2'd2);
          aborted = 1'b1;
        end
      end
    end

    // the checker prints its closing counts before the verdict
    @(negedge clk_i);
    done = 1'b1;
    @(negedge clk_i);
    done = 1'b0;
    if (err_cnt == 0 && !aborted) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
source/icache_pkg.sv
source/icache_ctrl.sv
source/icache_arrays.sv
source/icache_hit_select.sv
source/icache_repl_sel.sv
source/icache_top.sv
verification/icache_checker.sv
verification/icache_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the instruction cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps --Wno-fatal \
    --top-module icache_tb -f all.f; then
  echo "verilator build failed"
  exit 1
fi

if ! sim_out=$(./obj_dir/Vicache_tb 2>&1); then
  printf '%s\n' "$sim_out"
  echo "simulation exited with an error status"
  exit 1
fi
printf '%s\n' "$sim_out"

# verdict comes from the testbench output only
if printf '%s\n' "$sim_out" | grep -qx 'Finished with no errors'; then
  exit 0
fi
exit 1
